// File: design/rv_exec_pkg.sv
package rv_exec_pkg;

  typedef logic [31:0] word_t;     // data word, operands and results
  typedef logic [4:0]  reg_idx_t;  // architectural register index
  typedef logic [4:0]  alu_op_t;

  // alu op codes, same numbering as the core's ALU
  localparam alu_op_t ALU_IMM   = 5'b00000;  // pass operand b
  localparam alu_op_t ALU_ADD   = 5'b00001;
  localparam alu_op_t ALU_SUB   = 5'b00010;
  localparam alu_op_t ALU_AND   = 5'b00011;
  localparam alu_op_t ALU_XOR   = 5'b00100;
  localparam alu_op_t ALU_OR    = 5'b00101;
  localparam alu_op_t ALU_SL    = 5'b00110;  // logical left
  localparam alu_op_t ALU_SR    = 5'b00111;  // logical right
  localparam alu_op_t ALU_DIV   = 5'b01000;  // signed
  localparam alu_op_t ALU_SSR   = 5'b01001;  // arithmetic right
  localparam alu_op_t ALU_SLES  = 5'b01010;  // set less, signed
  localparam alu_op_t ALU_ULES  = 5'b01011;  // set less, unsigned
  localparam alu_op_t ALU_REMU  = 5'b01100;
  localparam alu_op_t ALU_MUL   = 5'b01101;  // low half
  localparam alu_op_t ALU_DIVU  = 5'b01110;
  localparam alu_op_t ALU_REM   = 5'b01111;  // signed
  localparam alu_op_t ALU_MULHU = 5'b10001;  // high half, unsigned

  typedef enum logic [1:0] {
    EXU_IDLE,
    EXU_DIV,
    EXU_DONE
  } exu_state_t;

  // micro-op layout is {alu_op, opa, opb, rd}
  localparam int UOP_W = $bits(alu_op_t) + 2 * $bits(word_t) + $bits(reg_idx_t);

endpackage

// File: design/rv_exec_top.sv
`timescale 1ns/10ps

module rv_exec_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  inst_valid,
  input  rv_exec_pkg::word_t    inst,
  output logic                  inst_ready,
  output logic                  result_valid,
  output rv_exec_pkg::reg_idx_t result_rd,
  output rv_exec_pkg::word_t    result_data,
  input  logic                  result_ready
);

  rv_exec_pkg::reg_idx_t         rs1;
  rv_exec_pkg::reg_idx_t         rs2;
  rv_exec_pkg::word_t            rsa;
  rv_exec_pkg::word_t            rsb;
  logic                          idu_push;
  logic [rv_exec_pkg::UOP_W-1:0] idu_uop;
  logic                          fifo_full;
  logic                          fifo_not_empty;
  logic [rv_exec_pkg::UOP_W-1:0] fifo_head;
  logic                          exu_pop;
  logic                          retire_fire;
  logic                          wb_en;

  assign retire_fire = result_valid && result_ready;
  assign wb_en       = retire_fire && (result_rd != '0);

  rv_idu idu (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_valid(inst_valid),
    .inst      (inst),
    .inst_ready(inst_ready),
    .fifo_full (fifo_full),
    .rs1       (rs1),
    .rs2       (rs2),
    .rsa       (rsa),
    .rsb       (rsb),
    .push      (idu_push),
    .uop_data  (idu_uop),
    .clear_en  (retire_fire),
    .clear_rd  (result_rd)
  );

  rv_issue_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (idu_push),
    .push_data(idu_uop),
    .pop      (exu_pop),
    .full     (fifo_full),
    .not_empty(fifo_not_empty),
    .head_data(fifo_head)
  );

  rv_exu exu (
    .clk         (clk),
    .rst_n       (rst_n),
    .uop_valid   (fifo_not_empty),
    .uop_data    (fifo_head),
    .pop         (exu_pop),
    .result_valid(result_valid),
    .result_ready(result_ready),
    .result_rd   (result_rd),
    .result_data (result_data)
  );

  rv_regfile rf (
    .clk  (clk),
    .rst_n(rst_n),
    .rs1  (rs1),
    .rs2  (rs2),
    .rsa  (rsa),
    .rsb  (rsb),
    .wen  (wb_en),
    .wrd  (result_rd),
    .wdata(result_data)
  );

endmodule

// File: design/rv_exu.sv
`timescale 1ns/10ps

module rv_exu (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          uop_valid,
  input  logic [rv_exec_pkg::UOP_W-1:0] uop_data,
  output logic                          pop,
  output logic                          result_valid,
  input  logic                          result_ready,
  output rv_exec_pkg::reg_idx_t         result_rd,
  output rv_exec_pkg::word_t            result_data
);

  rv_exec_pkg::exu_state_t state;
  rv_exec_pkg::alu_op_t    op;
  rv_exec_pkg::word_t      opa;
  rv_exec_pkg::word_t      opb;
  rv_exec_pkg::reg_idx_t   uop_rd;
  logic [63:0]             prod;
  rv_exec_pkg::word_t      alu_result;
  logic                    is_div;
  logic                    is_signed;
  logic                    a_neg;
  logic                    b_neg;
  rv_exec_pkg::word_t      a_mag;
  rv_exec_pkg::word_t      b_mag;
  rv_exec_pkg::word_t      div_q;    // dividend shifts out, quotient shifts in
  rv_exec_pkg::word_t      div_r;    // partial remainder
  rv_exec_pkg::word_t      div_d;    // divisor magnitude
  logic [4:0]              div_cnt;
  logic                    neg_q;
  logic                    neg_r;
  logic                    want_rem;
  logic [32:0]             r_shift;
  logic [32:0]             r_diff;
  logic                    r_ge;
  rv_exec_pkg::word_t      q_next;
  rv_exec_pkg::word_t      r_next;
  rv_exec_pkg::word_t      q_final;
  rv_exec_pkg::word_t      r_final;

  assign {op, opa, opb, uop_rd} = uop_data;
  assign prod = {32'b0, opa} * {32'b0, opb};

  always_comb begin
    case (op)
      rv_exec_pkg::ALU_IMM:   alu_result = opb;
      rv_exec_pkg::ALU_ADD:   alu_result = opa + opb;
      rv_exec_pkg::ALU_SUB:   alu_result = opa - opb;
      rv_exec_pkg::ALU_AND:   alu_result = opa & opb;
      rv_exec_pkg::ALU_XOR:   alu_result = opa ^ opb;
      rv_exec_pkg::ALU_OR:    alu_result = opa | opb;
      rv_exec_pkg::ALU_SL:    alu_result = opa << opb[4:0];
      rv_exec_pkg::ALU_SR:    alu_result = opa >> opb[4:0];
      rv_exec_pkg::ALU_SSR:   alu_result = $signed(opa) >>> opb[4:0];
      rv_exec_pkg::ALU_SLES:  alu_result = {31'b0, $signed(opa) < $signed(opb)};
      rv_exec_pkg::ALU_ULES:  alu_result = {31'b0, opa < opb};
      rv_exec_pkg::ALU_MUL:   alu_result = prod[31:0];
      rv_exec_pkg::ALU_MULHU: alu_result = prod[63:32];
      default:                alu_result = '0;  // divides finish in EXU_DIV
    endcase
  end

  assign is_div = (op == rv_exec_pkg::ALU_DIV) || (op == rv_exec_pkg::ALU_DIVU) ||
                  (op == rv_exec_pkg::ALU_REM) || (op == rv_exec_pkg::ALU_REMU);
  assign is_signed = (op == rv_exec_pkg::ALU_DIV) || (op == rv_exec_pkg::ALU_REM);
  assign a_neg = is_signed && opa[31];
  assign b_neg = is_signed && opb[31];
  assign a_mag = a_neg ? -opa : opa;
  assign b_mag = b_neg ? -opb : opb;

  // one restoring step
  assign r_shift = {div_r, div_q[31]};
  assign r_diff  = r_shift - {1'b0, div_d};
  assign r_ge    = !r_diff[32];
  assign r_next  = r_ge ? r_diff[31:0] : r_shift[31:0];
  assign q_next  = {div_q[30:0], r_ge};
  assign q_final = neg_q ? -q_next : q_next;
  assign r_final = neg_r ? -r_next : r_next;

  assign pop          = (state == rv_exec_pkg::EXU_IDLE) && uop_valid;
  assign result_valid = (state == rv_exec_pkg::EXU_DONE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= rv_exec_pkg::EXU_IDLE;
      div_cnt <= '0;
    end else begin
      case (state)
        rv_exec_pkg::EXU_IDLE: begin
          if (uop_valid) begin
            div_cnt <= '0;
            state   <= is_div ? rv_exec_pkg::EXU_DIV : rv_exec_pkg::EXU_DONE;
          end
        end
        rv_exec_pkg::EXU_DIV: begin
          div_cnt <= div_cnt + 5'd1;
          if (div_cnt == 5'd31) begin
            state <= rv_exec_pkg::EXU_DONE;
          end
        end
        rv_exec_pkg::EXU_DONE: begin
          if (result_ready) begin
            state <= rv_exec_pkg::EXU_IDLE;
          end
        end
        default: state <= rv_exec_pkg::EXU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      result_rd   <= uop_rd;
      result_data <= alu_result;
      div_q       <= a_mag;
      div_r       <= '0;
      div_d       <= b_mag;
      neg_q       <= (a_neg ^ b_neg) && (opb != '0);  // x/0 stays all ones
      neg_r       <= a_neg;                           // remainder takes dividend sign
      want_rem    <= (op == rv_exec_pkg::ALU_REM) || (op == rv_exec_pkg::ALU_REMU);
    end else if (state == rv_exec_pkg::EXU_DIV) begin
      div_q <= q_next;
      div_r <= r_next;
      if (div_cnt == 5'd31) begin
        result_data <= want_rem ? r_final : q_final;
      end
    end
  end

endmodule

// File: design/rv_idu.sv
`timescale 1ns/10ps

module rv_idu (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          inst_valid,
  input  rv_exec_pkg::word_t            inst,
  output logic                          inst_ready,
  input  logic                          fifo_full,
  output rv_exec_pkg::reg_idx_t         rs1,
  output rv_exec_pkg::reg_idx_t         rs2,
  input  rv_exec_pkg::word_t            rsa,
  input  rv_exec_pkg::word_t            rsb,
  output logic                          push,
  output logic [rv_exec_pkg::UOP_W-1:0] uop_data,
  input  logic                          clear_en,
  input  rv_exec_pkg::reg_idx_t         clear_rd
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  rv_exec_pkg::reg_idx_t rd;
  rv_exec_pkg::word_t    imm_i;
  rv_exec_pkg::word_t    imm_u;
  rv_exec_pkg::word_t    imm_sh;
  rv_exec_pkg::alu_op_t  alu_op;
  rv_exec_pkg::word_t    opa;
  rv_exec_pkg::word_t    opb;
  logic                  kept;      // OP, OP-IMM or LUI with a known funct
  logic                  use_rs1;
  logic                  use_rs2;
  logic [31:0]           busy;      // scoreboard, one bit per rd in flight
  logic                  hazard;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_u  = {inst[31:12], 12'b0};
  assign imm_sh = {27'b0, inst[24:20]};  // shamt

  always_comb begin
    kept    = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    alu_op  = rv_exec_pkg::ALU_ADD;
    opa     = rsa;
    opb     = rsb;
    case (opcode)
      OPC_OP: begin
        kept    = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = rv_exec_pkg::ALU_ADD;
          {7'b0000000, 3'b001}: alu_op = rv_exec_pkg::ALU_SL;
          {7'b0000000, 3'b010}: alu_op = rv_exec_pkg::ALU_SLES;
          {7'b0000000, 3'b011}: alu_op = rv_exec_pkg::ALU_ULES;
          {7'b0000000, 3'b100}: alu_op = rv_exec_pkg::ALU_XOR;
          {7'b0000000, 3'b101}: alu_op = rv_exec_pkg::ALU_SR;
          {7'b0000000, 3'b110}: alu_op = rv_exec_pkg::ALU_OR;
          {7'b0000000, 3'b111}: alu_op = rv_exec_pkg::ALU_AND;
          {7'b0100000, 3'b000}: alu_op = rv_exec_pkg::ALU_SUB;
          {7'b0100000, 3'b101}: alu_op = rv_exec_pkg::ALU_SSR;
          {7'b0000001, 3'b000}: alu_op = rv_exec_pkg::ALU_MUL;
          {7'b0000001, 3'b011}: alu_op = rv_exec_pkg::ALU_MULHU;
          {7'b0000001, 3'b100}: alu_op = rv_exec_pkg::ALU_DIV;
          {7'b0000001, 3'b101}: alu_op = rv_exec_pkg::ALU_DIVU;
          {7'b0000001, 3'b110}: alu_op = rv_exec_pkg::ALU_REM;
          {7'b0000001, 3'b111}: alu_op = rv_exec_pkg::ALU_REMU;
          default:              kept = 1'b0;  // mulh, mulhsu and unknown funct7
        endcase
      end
      OPC_OP_IMM: begin
        kept    = 1'b1;
        use_rs1 = 1'b1;
        opb     = imm_i;
        case (funct3)
          3'b000: alu_op = rv_exec_pkg::ALU_ADD;
          3'b010: alu_op = rv_exec_pkg::ALU_SLES;
          3'b011: alu_op = rv_exec_pkg::ALU_ULES;
          3'b100: alu_op = rv_exec_pkg::ALU_XOR;
          3'b110: alu_op = rv_exec_pkg::ALU_OR;
          3'b111: alu_op = rv_exec_pkg::ALU_AND;
          3'b001: begin
            alu_op = rv_exec_pkg::ALU_SL;
            opb    = imm_sh;
            kept   = (funct7 == 7'b0000000);
          end
          default: begin  // srli / srai
            opb    = imm_sh;
            alu_op = inst[30] ? rv_exec_pkg::ALU_SSR : rv_exec_pkg::ALU_SR;
            kept   = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end
      OPC_LUI: begin
        kept   = 1'b1;
        alu_op = rv_exec_pkg::ALU_IMM;
        opa    = '0;
        opb    = imm_u;
      end
      default: ;  // dropped opcode
    endcase
  end

  // waw on rd also holds, so a clear never frees a younger writer
  assign hazard = kept && ((use_rs1 && busy[rs1]) || (use_rs2 && busy[rs2]) || busy[rd]);

  assign inst_ready = !fifo_full && !hazard;
  assign push       = inst_valid && inst_ready && kept;
  assign uop_data   = {alu_op, opa, opb, rd};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      if (clear_en) begin
        busy[clear_rd] <= 1'b0;
      end
      if (push && rd != '0) begin
        busy[rd] <= 1'b1;  // x0 never marked
      end
    end
  end

endmodule

// File: design/rv_issue_fifo.sv
`timescale 1ns/10ps

module rv_issue_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          push,
  input  logic [rv_exec_pkg::UOP_W-1:0] push_data,
  input  logic                          pop,
  output logic                          full,
  output logic                          not_empty,
  output logic [rv_exec_pkg::UOP_W-1:0] head_data
);

  localparam int AW = $clog2(FIFO_DEPTH);

  logic [rv_exec_pkg::UOP_W-1:0] mem [FIFO_DEPTH];
  logic [AW:0]                   wr_ptr;  // msb is the wrap bit
  logic [AW:0]                   rd_ptr;
  logic                          do_push;
  logic                          do_pop;

  assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign not_empty = (wr_ptr != rd_ptr);
  assign head_data = mem[rd_ptr[AW-1:0]];

  assign do_push = push && !full;
  assign do_pop  = pop && not_empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[AW-1:0]] <= push_data;
    end
  end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_exec_pkg::reg_idx_t rs1,
  input  rv_exec_pkg::reg_idx_t rs2,
  output rv_exec_pkg::word_t    rsa,
  output rv_exec_pkg::word_t    rsb,
  input  logic                  wen,
  input  rv_exec_pkg::reg_idx_t wrd,
  input  rv_exec_pkg::word_t    wdata
);

  rv_exec_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wrd != '0) begin
      regs[wrd] <= wdata;
    end
  end

  // x0 hardwired
  assign rsa = (rs1 == '0) ? '0 : regs[rs1];
  assign rsb = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute path testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module rv_exec_tb \
  -f rv_exec_top.f -Mdir obj_dir \
  && ./obj_dir/Vrv_exec_tb | tee sim.log \
  || { echo "build or simulation run failed"; exit 1; }

grep -q '^>>> PASS$' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: rv_exec_top.f
design/rv_exec_pkg.sv
design/rv_regfile.sv
design/rv_issue_fifo.sv
design/rv_idu.sv
design/rv_exu.sv
design/rv_exec_top.sv
testbench/rv_exec_assertions.sv
testbench/rv_exec_tb.sv

// File: testbench/rv_exec_assertions.sv
`timescale 1ns/10ps

module rv_exec_assertions (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  result_valid,
  input logic                  result_ready,
  input rv_exec_pkg::reg_idx_t result_rd,
  input rv_exec_pkg::word_t    result_data,
  input logic                  push,
  input logic                  full
);

  // stalled retire record holds
  hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid && !result_ready |=> result_valid && $stable(result_rd) && $stable(result_data))
    else $error("retire record changed while result_ready was low");

  no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
    else $error("push into a full issue FIFO");

  idle_after_reset: assert property (@(posedge clk) !rst_n |=> !result_valid)
    else $error("result_valid high in the cycle after reset");

endmodule

bind rv_exec_top rv_exec_assertions checks (
  .clk         (clk),
  .rst_n       (rst_n),
  .result_valid(result_valid),
  .result_ready(result_ready),
  .result_rd   (result_rd),
  .result_data (result_data),
  .push        (idu_push),
  .full        (fifo_full)
);

// File: testbench/rv_exec_tb.sv
`timescale 1ns/10ps

module rv_exec_tb;

  localparam int CLK_HALF        = 5;
  localparam int NUM_INST        = 400;
  localparam int WATCHDOG_CYCLES = NUM_INST * 40 + 1000;
  // load, store, branch, system
  localparam logic [27:0] OTHER_OPC = {7'b0000011, 7'b0100011, 7'b1100011, 7'b1110011};

  logic                  clk;
  logic                  rst_n;
  logic                  inst_valid;
  rv_exec_pkg::word_t    inst;
  logic                  inst_ready;
  logic                  result_valid;
  rv_exec_pkg::reg_idx_t result_rd;
  rv_exec_pkg::word_t    result_data;
  logic                  result_ready;

  integer                seed;
  rv_exec_pkg::word_t    model_regs [32];
  rv_exec_pkg::reg_idx_t exp_rd_q [$];
  rv_exec_pkg::word_t    exp_data_q [$];
  int                    mismatches;
  int                    other_errors;
  int                    kept_count;
  int                    retired;

  rv_exec_top #(.FIFO_DEPTH(4)) uut (.*);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  function automatic rv_exec_pkg::reg_idx_t rand_reg();
    return rv_exec_pkg::reg_idx_t'({$random(seed)} % 8);  // x0-x7 only
  endfunction

  function automatic rv_exec_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv_exec_pkg::word_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                               input logic [4:0] rd, rs1);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic rv_exec_pkg::word_t next_inst(input int k);
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [2:0]  f3;
    logic [31:0] r;
    int          sel;
    case (k)
      0:  return {20'h80000, 5'd1, 7'b0110111};                // x1 = min int
      1:  return enc_i(12'hfff, 3'b000, 5'd2, 5'd0);           // x2 = -1
      2:  return enc_r(7'b0000001, 3'b100, 5'd3, 5'd1, 5'd2);  // div overflow
      3:  return enc_r(7'b0000001, 3'b110, 5'd4, 5'd1, 5'd2);
      4:  return enc_r(7'b0000001, 3'b100, 5'd5, 5'd1, 5'd0);  // divide by zero
      5:  return enc_r(7'b0000001, 3'b101, 5'd6, 5'd1, 5'd0);
      6:  return enc_r(7'b0000001, 3'b110, 5'd7, 5'd1, 5'd0);
      7:  return enc_r(7'b0000001, 3'b111, 5'd3, 5'd2, 5'd0);
      8:  return enc_i(12'd5, 3'b000, 5'd0, 5'd1);             // write to x0
      9:  return enc_r(7'b0000000, 3'b000, 5'd5, 5'd0, 5'd0);
      10: return enc_i(12'd1, 3'b000, 5'd1, 5'd1);             // chain on x1
      11: return enc_i(12'd1, 3'b000, 5'd1, 5'd1);
      default: ;
    endcase
    rd  = rand_reg();
    ra  = rand_reg();
    rb  = rand_reg();
    r   = $random(seed);
    sel = rand_below(16);
    if (sel < 6) begin
      sel = rand_below(16);
      if (sel < 8) return enc_r(7'b0000000, sel[2:0], rd, ra, rb);
      if (sel == 8) return enc_r(7'b0100000, 3'b000, rd, ra, rb);
      if (sel == 9) return enc_r(7'b0100000, 3'b101, rd, ra, rb);
      if (sel == 10) return enc_r(7'b0000001, 3'b000, rd, ra, rb);
      if (sel == 11) return enc_r(7'b0000001, 3'b011, rd, ra, rb);
      return enc_r(7'b0000001, 3'(sel - 8), rd, ra, rb);  // div, divu, rem, remu
    end
    if (sel < 12) begin
      f3 = r[14:12];
      if (f3 == 3'b001) return enc_i({7'b0, r[24:20]}, f3, rd, ra);
      if (f3 == 3'b101) return enc_i({1'b0, r[30], 5'b0, r[24:20]}, f3, rd, ra);
      return enc_i(r[31:20], f3, rd, ra);
    end
    if (sel < 14) return {r[31:12], rd, 7'b0110111};
    if (sel == 14) return {r[31:7], OTHER_OPC[7 * rand_below(4) +: 7]};
    return r[0] ? enc_i(12'hfff, 3'b000, rd, 5'd0) : {20'h80000, rd, 7'b0110111};
  endfunction

  function automatic rv_exec_pkg::word_t model_div(input rv_exec_pkg::word_t a, b,
                                                   input logic sgn, rem);
    if (b == '0) return rem ? a : 32'hffff_ffff;
    if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) return rem ? 32'h0 : a;
    if (sgn) return rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
    return rem ? a % b : a / b;
  endfunction

  // returns 1 when the instruction produces a result
  function automatic logic model_exec(input rv_exec_pkg::word_t ins,
                                      output rv_exec_pkg::word_t res);
    rv_exec_pkg::word_t a;
    rv_exec_pkg::word_t b;
    logic [63:0]        p;
    logic [6:0]         f7;
    logic [2:0]         f3;
    logic               kept;
    a    = model_regs[ins[19:15]];
    b    = model_regs[ins[24:20]];
    f7   = ins[31:25];
    f3   = ins[14:12];
    kept = 1'b1;
    res  = '0;
    case (ins[6:0])
      7'b0110011: ;
      7'b0010011: begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          b = {27'b0, ins[24:20]};  // shamt
        end else begin
          b  = {{20{ins[31]}}, ins[31:20]};
          f7 = '0;
        end
        kept = (f7 == 7'b0) || (f7 == 7'b0100000 && f3 == 3'b101);
      end
      7'b0110111: begin
        res = {ins[31:12], 12'b0};
        return 1'b1;
      end
      default: return 1'b0;
    endcase
    case ({f7, f3})
      {7'h00, 3'd0}: res = a + b;
      {7'h00, 3'd1}: res = a << b[4:0];
      {7'h00, 3'd2}: res = {31'b0, $signed(a) < $signed(b)};
      {7'h00, 3'd3}: res = {31'b0, a < b};
      {7'h00, 3'd4}: res = a ^ b;
      {7'h00, 3'd5}: res = a >> b[4:0];
      {7'h00, 3'd6}: res = a | b;
      {7'h00, 3'd7}: res = a & b;
      {7'h20, 3'd0}: res = a - b;
      {7'h20, 3'd5}: res = $signed(a) >>> b[4:0];
      {7'h01, 3'd0}: res = a * b;
      {7'h01, 3'd3}: begin
        p   = {32'b0, a} * {32'b0, b};
        res = p[63:32];
      end
      {7'h01, 3'd4}: res = model_div(a, b, 1'b1, 1'b0);
      {7'h01, 3'd5}: res = model_div(a, b, 1'b0, 1'b0);
      {7'h01, 3'd6}: res = model_div(a, b, 1'b1, 1'b1);
      {7'h01, 3'd7}: res = model_div(a, b, 1'b0, 1'b1);
      default:       kept = 1'b0;
    endcase
    return kept;
  endfunction

  task automatic check_retire();
    rv_exec_pkg::reg_idx_t exp_rd;
    rv_exec_pkg::word_t    exp_data;
    retired++;
    assert (exp_rd_q.size() != 0) else begin
      $display("%0t: result for rd %0d retired with nothing outstanding", $time, result_rd);
      other_errors++;
    end
    if (exp_rd_q.size() != 0) begin
      exp_rd   = exp_rd_q.pop_front();
      exp_data = exp_data_q.pop_front();
      assert (result_rd == exp_rd) else begin
        $display("Mismatch at %0t: result_rd got %0d expected %0d", $time, result_rd, exp_rd);
        mismatches++;
      end
      assert (result_data == exp_data) else begin
        $display("Mismatch at %0t: result_data got %h expected %h", $time, result_data,
                 exp_data);
        mismatches++;
      end
    end
  endtask

  initial begin
    rv_exec_pkg::word_t next;
    rv_exec_pkg::word_t res;
    int                 sent;
    seed         = 32'h8bef9d8c;
    rst_n        = 1'b0;
    inst_valid   = 1'b0;
    inst         = '0;
    result_ready = 1'b0;
    mismatches   = 0;
    other_errors = 0;
    kept_count   = 0;
    retired      = 0;
    sent         = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    next = next_inst(0);
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    while (sent < NUM_INST || exp_rd_q.size() != 0) begin
      @(negedge clk);
      inst_valid   = (sent < NUM_INST) && (rand_below(4) != 0);
      inst         = next;
      result_ready = (rand_below(4) != 0);
      #(CLK_HALF - 1);  // just before the rising edge
      if (result_valid && result_ready) check_retire();
      if (inst_valid && inst_ready) begin
        if (model_exec(inst, res)) begin
          exp_rd_q.push_back(inst[11:7]);
          exp_data_q.push_back(res);
          kept_count++;
          if (inst[11:7] != 5'd0) model_regs[inst[11:7]] = res;
        end
        sent++;
        next = next_inst(sent);
      end
    end
    @(negedge clk);
    #(CLK_HALF - 1);
    assert (!result_valid) else begin
      $display("%0t: result_valid still high after the last expected retire", $time);
      other_errors++;
    end
    assert (retired == kept_count) else begin
      $display("%0t: %0d results retired but %0d instructions were kept", $time, retired,
               kept_count);
      other_errors++;
    end
    $display("errors: %0d mismatches, %0d other; %0d of %0d kept instructions retired",
             mismatches, other_errors, retired, kept_count);
    if (mismatches == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
